// File: hw/otp_buf_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, status map and FSM states
// for the buffered OTP partition store.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package otp_buf_pkg;

  // Data, check and codeword widths of one stored word.
  localparam int WordW  = 64;
  localparam int CheckW = 8;
  localparam int CodeW  = WordW + CheckW;
  // Byte selects of the bus, one per data byte.
  localparam int SelW   = WordW / 8;

  // Upper bound of Depth, set by the 8-bit index field.
  localparam int MaxDepth = 256;
  localparam int IdxW     = $clog2(MaxDepth);

  // Address bit above the word region that selects the status page.
  localparam int StatusSel = IdxW;
  localparam int WbAdrW    = StatusSel + 1;

  // Word offsets inside the status page.
  localparam int StatusWord = 0;
  localparam int ClearWord  = 1;
  // Field positions within STATUS.
  localparam int StatusErrBit = 0;
  localparam int StatusIdxLsb = 8;

  typedef logic [WordW-1:0]  word_t;
  typedef logic [CheckW-1:0] check_t;
  // Check bits sit above the data bits.
  typedef logic [CodeW-1:0]  code_t;

  // Wishbone front-end states.
  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    ACK
  } fe_state_e;

endpackage

`default_nettype wire

// File: hw/otp_buf_wr_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single write/read port from the front
// end into the codeword register file.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

interface otp_buf_wr_if
  import otp_buf_pkg::*;
();

  // Write strobe, whole codeword.
  logic            wren;
  // Word index, wide enough to address beyond Depth.
  logic [IdxW-1:0] addr;
  code_t           wdata;
  // Data part of the addressed word.
  word_t           rdata;

  // Side that issues accesses.
  modport producer (
    output wren,
    output addr,
    output wdata,
    input  rdata
  );

  // Side that holds the words.
  modport store (
    input  wren,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

// File: hw/otp_buf_frontend.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic slave that shares the
// store's write port with fuse macro loads.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module otp_buf_frontend
  import otp_buf_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  // Wishbone classic slave.
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [WbAdrW-1:0] wb_adr_i,
  input  word_t             wb_dat_i,
  output word_t             wb_dat_o,
  output logic              wb_ack_o,
  // Raw codewords from the fuse macro, never stalled.
  input  logic              load_valid_i,
  input  logic [IdxW-1:0]   load_addr_i,
  input  code_t             load_code_i,
  // Port into the register file.
  otp_buf_wr_if.producer    wr,
  // Aggregated integrity status.
  input  logic              status_err_i,
  input  logic [IdxW-1:0]   status_idx_i,
  output logic              clr_o
);

  fe_state_e state_q, state_d;
  word_t     dat_q;
  word_t     status_word;
  logic      bus_req;
  logic      status_sel;
  logic      access_go;
  logic      bus_wr;

  // Lane-parity encoder: check bit j covers data bits with index mod 8 == j.
  function automatic check_t lane_enc(input word_t data);
    check_t chk;
    chk = '0;
    for (int i = 0; i < WordW; i++) begin
      chk[i % CheckW] ^= data[i];
    end
    return chk;
  endfunction

  assign bus_req    = wb_cyc_i & wb_stb_i;
  assign status_sel = wb_adr_i[StatusSel];

  // The access is performed only in a cycle without a load.
  assign access_go = (state_q == ACCESS) & bus_req & ~load_valid_i;
  assign bus_wr    = access_go & wb_we_i & ~status_sel;

  // CLEAR is any write to the second status word.
  assign clr_o = access_go & wb_we_i & status_sel &
                 (wb_adr_i[IdxW-1:0] == IdxW'(ClearWord));

  // STATUS layout, all other bits read zero.
  always_comb begin
    status_word = '0;
    if (wb_adr_i[IdxW-1:0] == IdxW'(StatusWord)) begin
      status_word[StatusErrBit] = status_err_i;
      status_word[StatusIdxLsb +: IdxW] = status_idx_i;
    end
  end

  // Loads win the port. Bus writes are encoded here.
  always_comb begin
    wr.wren  = load_valid_i | bus_wr;
    wr.addr  = wb_adr_i[IdxW-1:0];
    wr.wdata = {lane_enc(wb_dat_i), wb_dat_i};
    if (load_valid_i) begin
      wr.addr  = load_addr_i;
      wr.wdata = load_code_i;
    end
  end

  // Next-state logic.
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (bus_req) begin
          state_d = ACCESS;
        end
      end
      ACCESS: begin
        // Abandoned cycle: drop back without acting.
        if (!bus_req) begin
          state_d = IDLE;
        end else if (!load_valid_i) begin
          state_d = ACK;
        end
      end
      ACK: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Read data is captured in ACCESS and held through ACK.
  always_ff @(posedge clk_i) begin
    if (access_go && !wb_we_i) begin
      dat_q <= status_sel ? status_word : wr.rdata;
    end
  end

  assign wb_dat_o = dat_q;
  assign wb_ack_o = (state_q == ACK);

endmodule

`default_nettype wire

// File: hw/otp_ecc_reg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Codeword register file, one write port,
// one read port, all words out in parallel.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module otp_ecc_reg
  import otp_buf_pkg::*;
#(
  parameter int Depth = 16
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Write and read port from the front end.
  otp_buf_wr_if.store         wr,
  // Every stored codeword, for the checkers.
  output code_t [Depth-1:0]   code_o
);

  // Index width, at least one bit.
  localparam int AddrW = (Depth > 1) ? $clog2(Depth) : 1;

  code_t [Depth-1:0] code_q;
  logic              in_range;
  logic [AddrW-1:0]  idx;

  // Addresses at or beyond Depth are neither written nor read.
  assign in_range = int'(wr.addr) < Depth;

  always_comb begin
    idx = '0;
    if (in_range) begin
      idx = wr.addr[AddrW-1:0];
    end
  end

  // Data part only. Out of range reads zero.
  always_comb begin
    wr.rdata = '0;
    if (in_range) begin
      wr.rdata = code_q[idx][WordW-1:0];
    end
  end

  // Reset leaves zero codewords, which have valid parity.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      code_q <= '0;
    end else if (wr.wren && in_range) begin
      // The whole codeword is replaced.
      code_q[idx] <= wr.wdata;
    end
  end

  assign code_o = code_q;

endmodule

`default_nettype wire

// File: hw/otp_ecc_lane_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lane-parity checker for one codeword.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module otp_ecc_lane_chk
  import otp_buf_pkg::*;
(
  input  code_t code_i,
  output logic  err_o
);

  word_t  data;
  check_t stored;
  check_t recomputed;

  // Check bits sit above the data.
  assign data   = code_i[WordW-1:0];
  assign stored = code_i[CodeW-1:WordW];

  // Lane j folds every data bit whose index mod 8 is j.
  always_comb begin
    recomputed = '0;
    for (int i = 0; i < WordW; i++) begin
      recomputed[i % CheckW] ^= data[i];
    end
  end

  // Any lane that disagrees flags the word.
  // Detection only, no attempt at correction.
  assign err_o = |(recomputed ^ stored);

endmodule

`default_nettype wire

// File: hw/otp_ecc_err_agg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sticky integrity flag and lowest failing
// word index, cleared by the front end.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module otp_ecc_err_agg
  import otp_buf_pkg::*;
#(
  parameter int Depth = 16
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // One flag per stored word.
  input  logic [Depth-1:0] err_i,
  // One-cycle clear from a CLEAR write.
  input  logic             clr_i,
  output logic             err_o,
  output logic [IdxW-1:0]  idx_o
);

  logic            any_err;
  logic [IdxW-1:0] low_idx;
  logic            err_q;
  logic [IdxW-1:0] idx_q;

  assign any_err = |err_i;

  // Priority encoder, lowest index wins.
  always_comb begin
    low_idx = '0;
    for (int i = Depth - 1; i >= 0; i--) begin
      if (err_i[i]) begin
        low_idx = IdxW'(i);
      end
    end
  end

  // Clear has priority. A word still bad sets the flag again next cycle.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
      idx_q <= '0;
    end else if (clr_i) begin
      err_q <= 1'b0;
      idx_q <= '0;
    end else if (any_err && !err_q) begin
      // First failure is latched, later ones keep it.
      err_q <= 1'b1;
      idx_q <= low_idx;
    end
  end

  assign err_o = err_q;
  assign idx_o = idx_q;

endmodule

`default_nettype wire

// File: hw/otp_buf_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Buffered OTP partition store with bus
// access, macro loads and integrity checks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module otp_buf_top
  import otp_buf_pkg::*;
#(
  parameter int Depth = 16
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Wishbone classic slave.
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [WbAdrW-1:0] wb_adr_i,
  // Words are written whole, byte selects have no effect.
  input  logic [SelW-1:0]   wb_sel_i,
  input  word_t             wb_dat_i,
  output word_t             wb_dat_o,
  output logic              wb_ack_o,
  // Codewords read out of the fuse macro.
  input  logic              load_valid_i,
  input  logic [IdxW-1:0]   load_addr_i,
  input  code_t             load_code_i,
  // Sticky integrity error.
  output logic              err_o
);

  code_t [Depth-1:0] stored_code;
  logic  [Depth-1:0] word_err;
  logic  [IdxW-1:0]  err_idx;
  logic              err_clr;

  // Shared port between front end and storage.
  otp_buf_wr_if wr_if ();

  otp_buf_frontend u_frontend (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .load_valid_i (load_valid_i),
    .load_addr_i  (load_addr_i),
    .load_code_i  (load_code_i),
    .wr           (wr_if.producer),
    .status_err_i (err_o),
    .status_idx_i (err_idx),
    .clr_o        (err_clr)
  );

  otp_ecc_reg #(
    .Depth (Depth)
  ) u_ecc_reg (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .wr     (wr_if.store),
    .code_o (stored_code)
  );

  // One checker per stored word.
  for (genvar k = 0; k < Depth; k++) begin : gen_lane_chk
    otp_ecc_lane_chk u_lane_chk (
      .code_i (stored_code[k]),
      .err_o  (word_err[k])
    );
  end

  otp_ecc_err_agg #(
    .Depth (Depth)
  ) u_err_agg (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .err_i  (word_err),
    .clr_i  (err_clr),
    .err_o  (err_o),
    .idx_o  (err_idx)
  );

endmodule

`default_nettype wire

// File: dv/otp_buf_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus and integrity-flag properties, bound
// into the store's top level.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module otp_buf_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic wb_stb_i,
  input logic wb_ack_o,
  input logic err_o,
  input logic wren_i,
  input logic clr_i
);

  // Set once anything has been written since reset.
  logic wrote_q;
  // Latches the first property failure.
  logic failed = 1'b0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wrote_q <= 1'b0;
    end else if (wren_i) begin
      wrote_q <= 1'b1;
    end
  end

  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |=> !wb_ack_o)
  else begin
    failed = 1'b1;
    $error("ack held for more than one cycle");
  end

  ack_with_stb: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |-> wb_stb_i)
  else begin
    failed = 1'b1;
    $error("ack raised without stb");
  end

  // Zero codewords after reset are valid.
  err_needs_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !wrote_q |-> !err_o)
  else begin
    failed = 1'b1;
    $error("err raised before any write");
  end

  err_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_o && !clr_i |=> err_o)
  else begin
    failed = 1'b1;
    $error("err dropped without a clear");
  end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and power-on reset.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int Period    = 20,
  parameter int RstCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  // Reset drops on a falling edge, away from the active edge.
  initial begin
    rst_no = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/tb_otp_buf.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench of the OTP buffer:
// bus access, loads, integrity, stalls.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module tb_otp_buf
  import otp_buf_pkg::*;
();

  localparam int Depth = 16;
  // Roughly 500 cycles of tests, with a wide margin.
  localparam int MaxCycles = 2000;
  localparam logic [WbAdrW-1:0] StatusAdr = WbAdrW'((1 << StatusSel) + StatusWord);
  localparam logic [WbAdrW-1:0] ClearAdr  = WbAdrW'((1 << StatusSel) + ClearWord);

  logic              clk;
  logic              rst_n;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [WbAdrW-1:0] wb_adr;
  logic [SelW-1:0]   wb_sel;
  word_t             wb_dat_w;
  word_t             wb_dat_r;
  logic              wb_ack;
  logic              load_valid;
  logic [IdxW-1:0]   load_addr;
  code_t             load_code;
  logic              err;
  integer            seed;
  int                cycles;
  // Expected data part of every stored word.
  word_t             exp_mem [Depth];

  tb_clk_gen #(.Period(20), .RstCycles(8)) u_clk_gen (.clk_o(clk), .rst_no(rst_n));

  otp_buf_top #(.Depth(Depth)) UUT (
    .clk_i (clk), .rst_ni (rst_n),
    .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
    .wb_sel_i (wb_sel), .wb_dat_i (wb_dat_w), .wb_dat_o (wb_dat_r), .wb_ack_o (wb_ack),
    .load_valid_i (load_valid), .load_addr_i (load_addr), .load_code_i (load_code),
    .err_o (err)
  );

  bind otp_buf_top otp_buf_chk u_chk (
    .clk_i (clk_i), .rst_ni (rst_ni), .wb_stb_i (wb_stb_i), .wb_ack_o (wb_ack_o),
    .err_o (err_o), .wren_i (wr_if.wren), .clr_i (err_clr)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles.", MaxCycles);
      $display("tests failed");
      $fatal(1);
    end
  end

  // A failed bound property ends the run at once.
  always @(negedge clk) begin
    if (UUT.u_chk.failed) begin
      fail_run("A bound assertion failed.");
    end
  end

  // Lane j is the XOR of data bits j, j+8, j+16 and so on.
  function automatic code_t encode(input word_t d);
    check_t c;
    for (int j = 0; j < CheckW; j++) begin
      c[j] = 1'b0;
      for (int k = j; k < WordW; k += CheckW) c[j] = c[j] ^ d[k];
    end
    return {c, d};
  endfunction

  function automatic word_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %h, expected %h", $time, what, got, exp);
      fail_run("Word mismatch.");
    end
  endtask

  task automatic check_err(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %b, expected %b", $time, what, got, exp);
      fail_run("Error flag mismatch.");
    end
  endtask

  task automatic check_idx(input string what, input logic [IdxW-1:0] got,
                           input logic [IdxW-1:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %0d, expected %0d", $time, what, got, exp);
      fail_run("Index mismatch.");
    end
  endtask

  // Holds stb through the ack cycle, drops it on the next falling edge.
  task automatic bus_access(input logic we, input logic [WbAdrW-1:0] adr,
                            input word_t wdat, output word_t rdat);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    rdat = wb_dat_r;
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic load_word(input logic [IdxW-1:0] adr, input code_t code);
    @(negedge clk);
    load_valid = 1'b1;
    load_addr  = adr;
    load_code  = code;
    @(negedge clk);
    load_valid = 1'b0;
  endtask

  task automatic check_status(input logic exp_err, input logic [IdxW-1:0] exp_idx);
    word_t r;
    word_t exp;
    bus_access(1'b0, StatusAdr, '0, r);
    exp = '0;
    exp[StatusErrBit] = exp_err;
    exp[StatusIdxLsb +: IdxW] = exp_idx;
    check_err("STATUS error bit", r[StatusErrBit], exp_err);
    check_idx("STATUS index", r[StatusIdxLsb +: IdxW], exp_idx);
    check_word("STATUS word", r, exp);
  endtask

  task automatic check_all_words();
    word_t r;
    for (int i = 0; i < Depth; i++) begin
      bus_access(1'b0, WbAdrW'(i), '0, r);
      check_word($sformatf("word %0d", i), r, exp_mem[i]);
    end
  endtask

  task automatic test_bus_rw();
    word_t r;
    for (int i = 0; i < Depth; i++) begin
      exp_mem[i] = rand_word();
      bus_access(1'b1, WbAdrW'(i), exp_mem[i], r);
    end
    check_all_words();
    check_err("err_o after bus writes", err, 1'b0);
    check_status(1'b0, '0);
  endtask

  task automatic test_valid_loads();
    for (int i = 0; i < Depth; i++) begin
      exp_mem[i] = rand_word();
      load_word(IdxW'(i), encode(exp_mem[i]));
    end
    check_all_words();
    check_err("err_o after valid loads", err, 1'b0);
  endtask

  // A single flipped bit, data or check, breaks one lane.
  task automatic test_bad_loads();
    int bit_pos;
    exp_mem[5] = rand_word();
    bit_pos = $unsigned($random(seed)) % CodeW;
    load_word(IdxW'(5), encode(exp_mem[5]) ^ (code_t'(1) << bit_pos));
    exp_mem[9] = rand_word();
    bit_pos = $unsigned($random(seed)) % CodeW;
    load_word(IdxW'(9), encode(exp_mem[9]) ^ (code_t'(1) << bit_pos));
    // Flag registers one edge after the write.
    @(negedge clk);
    check_err("err_o after bad loads", err, 1'b1);
    check_status(1'b1, IdxW'(5));
  endtask

  task automatic test_clear_repair();
    word_t r;
    // Both bad words still stored, so the flag comes back.
    bus_access(1'b1, ClearAdr, '0, r);
    check_status(1'b1, IdxW'(5));
    exp_mem[5] = rand_word();
    bus_access(1'b1, WbAdrW'(5), exp_mem[5], r);
    exp_mem[9] = rand_word();
    bus_access(1'b1, WbAdrW'(9), exp_mem[9], r);
    bus_access(1'b1, ClearAdr, '0, r);
    @(negedge clk);
    check_err("err_o after repair", err, 1'b0);
    check_status(1'b0, '0);
    check_all_words();
  endtask

  // Bus write to word 12 stalls behind three loads to words 1 to 3.
  task automatic test_backpressure();
    word_t bus_dat;
    word_t ld_dat [3];
    bus_dat = rand_word();
    foreach (ld_dat[k]) ld_dat[k] = rand_word();
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = WbAdrW'(12);
    wb_dat_w = bus_dat;
    for (int k = 0; k < 3; k++) begin
      load_valid = 1'b1;
      load_addr  = IdxW'(k + 1);
      load_code  = encode(ld_dat[k]);
      @(negedge clk);
      if (wb_ack) fail_run("Bus write was acknowledged while loads held the write port.");
    end
    load_valid = 1'b0;
    while (!wb_ack) @(negedge clk);
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    foreach (ld_dat[k]) exp_mem[k + 1] = ld_dat[k];
    exp_mem[12] = bus_dat;
    check_all_words();
    check_err("err_o after back-pressure", err, 1'b0);
  endtask

  task automatic test_out_of_range();
    word_t r;
    bus_access(1'b1, WbAdrW'(20), rand_word(), r);
    bus_access(1'b0, WbAdrW'(20), '0, r);
    check_word("read beyond Depth", r, '0);
    check_all_words();
  endtask

  initial begin
    seed       = 32'h7a78;
    cycles     = 0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_sel     = '1;
    wb_dat_w   = '0;
    load_valid = 1'b0;
    load_addr  = '0;
    load_code  = '0;
    @(posedge rst_n);
    check_err("err_o after reset", err, 1'b0);
    test_bus_rw();
    test_valid_loads();
    test_bad_loads();
    test_clear_repair();
    test_backpressure();
    test_out_of_range();
    if (UUT.u_chk.failed) begin
      fail_run("A bound assertion failed.");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: list.f
hw/otp_buf_pkg.sv
hw/otp_buf_wr_if.sv
hw/otp_buf_frontend.sv
hw/otp_ecc_reg.sv
hw/otp_ecc_lane_chk.sv
hw/otp_ecc_err_agg.sv
hw/otp_buf_top.sv
dv/otp_buf_chk.sv
dv/tb_clk_gen.sv
dv/tb_otp_buf.sv

// File: Bender.yml
package:
  name: otp_buf

sources:
  # Package first, then the interface and the RTL leaves up to the top.
  - hw/otp_buf_pkg.sv
  - hw/otp_buf_wr_if.sv
  - hw/otp_buf_frontend.sv
  - hw/otp_ecc_reg.sv
  - hw/otp_ecc_lane_chk.sv
  - hw/otp_ecc_err_agg.sv
  - hw/otp_buf_top.sv
  - target: test
    files:
      - dv/otp_buf_chk.sv
      - dv/tb_clk_gen.sv
      - dv/tb_otp_buf.sv
